//--- hdl/csr_pkg.sv
package csr_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [4:0]      exc_code_t;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_t;

    typedef enum logic [2:0] {
        CSR_RW,
        CSR_RS,
        CSR_RC,
        CSR_RWI,
        CSR_RSI,
        CSR_RCI
    } csr_op_t;

    // machine level
    localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t ADDR_MISA     = 12'h301;
    localparam csr_addr_t ADDR_MEDELEG  = 12'h302;
    localparam csr_addr_t ADDR_MIDELEG  = 12'h303;
    localparam csr_addr_t ADDR_MIE      = 12'h304;
    localparam csr_addr_t ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_MEPC     = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t ADDR_MTVAL    = 12'h343;
    localparam csr_addr_t ADDR_MIP      = 12'h344;
    // supervisor level
    localparam csr_addr_t ADDR_SSTATUS  = 12'h100;
    localparam csr_addr_t ADDR_SIE      = 12'h104;
    localparam csr_addr_t ADDR_STVEC    = 12'h105;
    localparam csr_addr_t ADDR_SSCRATCH = 12'h140;
    localparam csr_addr_t ADDR_SEPC     = 12'h141;
    localparam csr_addr_t ADDR_SCAUSE   = 12'h142;
    localparam csr_addr_t ADDR_STVAL    = 12'h143;
    localparam csr_addr_t ADDR_SIP      = 12'h144;
    localparam csr_addr_t ADDR_SATP     = 12'h180;

    localparam exc_code_t EXC_IAM  = 5'd0;
    localparam exc_code_t EXC_IAF  = 5'd1;
    localparam exc_code_t EXC_II   = 5'd2;
    localparam exc_code_t EXC_BP   = 5'd3;
    localparam exc_code_t EXC_LAM  = 5'd4;
    localparam exc_code_t EXC_LAF  = 5'd5;
    localparam exc_code_t EXC_SAM  = 5'd6;
    localparam exc_code_t EXC_SAF  = 5'd7;
    localparam exc_code_t EXC_EC   = 5'd8;
    localparam exc_code_t EXC_IPF  = 5'd12;
    localparam exc_code_t EXC_LPF  = 5'd13;
    localparam exc_code_t EXC_SPF  = 5'd15;
    // low bits give the privilege the return needs
    localparam exc_code_t EXC_SRET = 5'd25;
    localparam exc_code_t EXC_MRET = 5'd27;

    localparam exc_code_t IRQ_SSI = 5'd1;
    localparam exc_code_t IRQ_MSI = 5'd3;
    localparam exc_code_t IRQ_STI = 5'd5;
    localparam exc_code_t IRQ_MTI = 5'd7;
    localparam exc_code_t IRQ_SEI = 5'd9;
    localparam exc_code_t IRQ_MEI = 5'd11;

    // rv32 with a, i, m, s, u
    localparam xlen_t MISA_VALUE    = 32'h4014_1101;
    localparam xlen_t MSTATUS_WMASK = 32'h004E_19AA;
    localparam xlen_t SSTATUS_MASK  = 32'h000C_0122;
    localparam xlen_t SIE_MASK      = 32'h0000_0222;
    localparam xlen_t MIP_WMASK     = 32'h0000_0222;
    // exceptions plus u and s ecall, interrupt bits fall inside
    localparam xlen_t DELEG_MASK    = 32'h0000_B3FF;
    localparam xlen_t TVEC_MASK     = 32'hFFFF_FFFD;
    localparam xlen_t EPC_MASK      = 32'hFFFF_FFFC;

endpackage

//--- hdl/csr_access.sv
`timescale 1ns/1ps

module csr_access import csr_pkg::*; (
    input  logic       csr_en_i,
    input  csr_op_t    csr_op_i,
    input  csr_addr_t  csr_addr_i,
    input  xlen_t      csr_src_i,
    input  logic [4:0] csr_uimm_i,
    input  priv_t      priv_i,
    input  xlen_t      rd_data_i,
    input  logic       rd_hit_i,
    output csr_addr_t  rd_addr_o,
    output xlen_t      csr_rdata_o,
    output logic       csr_illegal_o,
    output logic       wr_en_o,
    output csr_addr_t  wr_addr_o,
    output xlen_t      wr_data_o
);
    logic  use_imm;
    logic  is_rw;
    logic  is_set;
    logic  is_clr;
    logic  does_write;
    logic  priv_low;
    xlen_t operand;

    assign use_imm = csr_op_i inside {CSR_RWI, CSR_RSI, CSR_RCI};
    assign is_rw   = csr_op_i inside {CSR_RW, CSR_RWI};
    assign is_set  = csr_op_i inside {CSR_RS, CSR_RSI};
    assign is_clr  = csr_op_i inside {CSR_RC, CSR_RCI};

    assign operand = use_imm ? xlen_t'(csr_uimm_i) : csr_src_i;

    // set or clear with a zero operand is a pure read
    assign does_write = is_rw || ((is_set || is_clr) && (operand != '0));

    // address bits 9:8 hold the lowest mode allowed
    assign priv_low = 2'(priv_i) < csr_addr_i[9:8];

    assign rd_addr_o     = csr_addr_i;
    assign csr_rdata_o   = rd_data_i;
    assign csr_illegal_o = csr_en_i & (~rd_hit_i | priv_low);

    always_comb begin
        if (is_set) begin
            wr_data_o = rd_data_i | operand;
        end else if (is_clr) begin
            wr_data_o = rd_data_i & ~operand;
        end else begin
            wr_data_o = operand;
        end
    end

    assign wr_en_o   = csr_en_i & ~csr_illegal_o & does_write;
    assign wr_addr_o = csr_addr_i;

endmodule

//--- hdl/csr_write_pipe.sv
`timescale 1ns/1ps

module csr_write_pipe import csr_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      wr_en_i,
    input  csr_addr_t wr_addr_i,
    input  xlen_t     wr_data_i,
    input  logic      flush_i,
    output logic      commit_en_o,
    output csr_addr_t commit_addr_o,
    output xlen_t     commit_data_o
);
    logic      en_s1, en_s2;
    csr_addr_t addr_s1, addr_s2;
    xlen_t     data_s1, data_s2;

    // a flush kills the entry and both stages
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            en_s1 <= 1'b0;
            en_s2 <= 1'b0;
        end else begin
            en_s1 <= wr_en_i & ~flush_i;
            en_s2 <= en_s1 & ~flush_i;
        end
    end

    always_ff @(posedge clk) begin
        addr_s1 <= wr_addr_i;
        data_s1 <= wr_data_i;
        addr_s2 <= addr_s1;
        data_s2 <= data_s1;
    end

    assign commit_en_o   = en_s2 & ~flush_i;
    assign commit_addr_o = addr_s2;
    assign commit_data_o = data_s2;

endmodule

//--- hdl/csr_file.sv
`timescale 1ns/1ps

module csr_file import csr_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       commit_en_i,
    input  csr_addr_t  commit_addr_i,
    input  xlen_t      commit_data_i,
    input  csr_addr_t  rd_addr_i,
    input  priv_t      priv_i,
    input  logic       trap_enter_i,
    input  logic       trap_to_s_i,
    input  logic       mret_i,
    input  logic       sret_i,
    input  exc_code_t  trap_cause_i,
    input  logic       trap_irq_i,
    input  xlen_t      trap_pc_i,
    input  xlen_t      trap_inst_i,
    input  xlen_t      trap_vaddr_i,
    input  logic [2:0] hw_pending_i,
    output xlen_t      rd_data_o,
    output logic       rd_hit_o,
    output xlen_t      mtvec_o,
    output xlen_t      stvec_o,
    output xlen_t      mepc_o,
    output xlen_t      sepc_o,
    output xlen_t      medeleg_o,
    output xlen_t      mideleg_o,
    output xlen_t      mie_o,
    output xlen_t      mip_o,
    output logic       mstatus_mie_o,
    output logic       mstatus_sie_o,
    output priv_t      mstatus_mpp_o,
    output priv_t      mstatus_spp_o,
    output logic       mstatus_tsr_o
);
    xlen_t mstatus, medeleg, mideleg, mie, mip_sw, mtvec, mscratch, mepc, mcause, mtval;
    xlen_t stvec, sscratch, sepc, scause, stval, satp;
    xlen_t mip, tval, cause, wdata, mst_new;

    // software bits plus synchronized msip, mtip, meip
    assign mip = mip_sw | {20'b0, hw_pending_i[2], 3'b0, hw_pending_i[1], 3'b0,
                           hw_pending_i[0], 3'b0};

    always_comb begin
        rd_hit_o = 1'b1;
        case (rd_addr_i)
            ADDR_MSTATUS:  rd_data_o = mstatus;
            ADDR_MISA:     rd_data_o = MISA_VALUE;
            ADDR_MEDELEG:  rd_data_o = medeleg;
            ADDR_MIDELEG:  rd_data_o = mideleg;
            ADDR_MIE:      rd_data_o = mie;
            ADDR_MTVEC:    rd_data_o = mtvec;
            ADDR_MSCRATCH: rd_data_o = mscratch;
            ADDR_MEPC:     rd_data_o = mepc;
            ADDR_MCAUSE:   rd_data_o = mcause;
            ADDR_MTVAL:    rd_data_o = mtval;
            ADDR_MIP:      rd_data_o = mip;
            ADDR_SSTATUS:  rd_data_o = mstatus & SSTATUS_MASK;
            ADDR_SIE:      rd_data_o = mie & SIE_MASK;
            ADDR_STVEC:    rd_data_o = stvec;
            ADDR_SSCRATCH: rd_data_o = sscratch;
            ADDR_SEPC:     rd_data_o = sepc;
            ADDR_SCAUSE:   rd_data_o = scause;
            ADDR_STVAL:    rd_data_o = stval;
            ADDR_SIP:      rd_data_o = mip & SIE_MASK;
            ADDR_SATP:     rd_data_o = satp;
            default: begin
                rd_data_o = '0;
                rd_hit_o  = 1'b0;
            end
        endcase
    end

    always_comb begin
        tval = '0;
        if (!trap_irq_i) begin
            case (trap_cause_i)
                EXC_II:                           tval = trap_inst_i;
                EXC_IAM, EXC_IAF, EXC_BP, EXC_IPF: tval = trap_pc_i;
                EXC_LAM, EXC_LAF, EXC_SAM, EXC_SAF, EXC_LPF, EXC_SPF: tval = trap_vaddr_i;
                default:                          tval = '0;
            endcase
        end
    end

    assign cause = {trap_irq_i, 26'b0, trap_cause_i};
    assign wdata = commit_data_i;
    // mpp value 2 is reserved, keep the old field
    assign mst_new = (mstatus & ~MSTATUS_WMASK) | (wdata & MSTATUS_WMASK);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            {mstatus, medeleg, mideleg, mie, mip_sw, mtvec, mscratch, mepc} <= '0;
            {mcause, mtval, stvec, sscratch, sepc, scause, stval, satp} <= '0;
        end else begin
            if (commit_en_i) begin
                case (commit_addr_i)
                    ADDR_MSTATUS: begin
                        mstatus <= mst_new;
                        if (wdata[12:11] == 2'b10) begin
                            mstatus[12:11] <= mstatus[12:11];
                        end
                    end
                    ADDR_SSTATUS:  mstatus <= (mstatus & ~SSTATUS_MASK) | (wdata & SSTATUS_MASK);
                    ADDR_MEDELEG:  medeleg <= wdata & DELEG_MASK;
                    ADDR_MIDELEG:  mideleg <= wdata & DELEG_MASK;
                    ADDR_MIE:      mie <= wdata;
                    ADDR_SIE:      mie <= (mie & ~SIE_MASK) | (wdata & SIE_MASK);
                    ADDR_MIP:      mip_sw <= wdata & MIP_WMASK;
                    ADDR_SIP:      mip_sw <= wdata & SIE_MASK;
                    ADDR_MTVEC:    mtvec <= wdata & TVEC_MASK;
                    ADDR_STVEC:    stvec <= wdata & TVEC_MASK;
                    ADDR_MEPC:     mepc <= wdata & EPC_MASK;
                    ADDR_SEPC:     sepc <= wdata & EPC_MASK;
                    ADDR_MSCRATCH: mscratch <= wdata;
                    ADDR_SSCRATCH: sscratch <= wdata;
                    ADDR_MCAUSE:   mcause <= wdata;
                    ADDR_SCAUSE:   scause <= wdata;
                    ADDR_MTVAL:    mtval <= wdata;
                    ADDR_STVAL:    stval <= wdata;
                    ADDR_SATP:     satp <= wdata;
                    default: ;
                endcase
            end
            // trap side comes last so it wins over a commit
            if (trap_enter_i && trap_to_s_i) begin
                mstatus[8] <= priv_i[0];
                mstatus[5] <= mstatus[1];
                mstatus[1] <= 1'b0;
                scause     <= cause;
                sepc       <= trap_pc_i & EPC_MASK;
                stval      <= tval;
            end else if (trap_enter_i) begin
                mstatus[12:11] <= priv_i;
                mstatus[7]     <= mstatus[3];
                mstatus[3]     <= 1'b0;
                mcause         <= cause;
                mepc           <= trap_pc_i & EPC_MASK;
                mtval          <= tval;
            end
            if (mret_i) begin
                mstatus[3]     <= mstatus[7];
                mstatus[7]     <= 1'b1;
                mstatus[12:11] <= PRIV_U;
                if (mstatus[12:11] != PRIV_M) begin
                    mstatus[17] <= 1'b0;
                end
            end
            if (sret_i) begin
                mstatus[1]  <= mstatus[5];
                mstatus[5]  <= 1'b1;
                mstatus[8]  <= 1'b0;
                mstatus[17] <= 1'b0;
            end
        end
    end

    assign mtvec_o       = mtvec;
    assign stvec_o       = stvec;
    assign mepc_o        = mepc;
    assign sepc_o        = sepc;
    assign medeleg_o     = medeleg;
    assign mideleg_o     = mideleg;
    assign mie_o         = mie;
    assign mip_o         = mip;
    assign mstatus_mie_o = mstatus[3];
    assign mstatus_sie_o = mstatus[1];
    assign mstatus_mpp_o = priv_t'(mstatus[12:11]);
    assign mstatus_spp_o = priv_t'({1'b0, mstatus[8]});
    assign mstatus_tsr_o = mstatus[22];

endmodule

//--- hdl/trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl import csr_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      trap_i,
    input  exc_code_t trap_code_i,
    input  logic      trap_irq_i,
    input  xlen_t     mtvec_i,
    input  xlen_t     stvec_i,
    input  xlen_t     mepc_i,
    input  xlen_t     sepc_i,
    input  xlen_t     medeleg_i,
    input  xlen_t     mideleg_i,
    input  priv_t     mstatus_mpp_i,
    input  priv_t     mstatus_spp_i,
    input  logic      mstatus_tsr_i,
    output priv_t     priv_o,
    output xlen_t     target_pc_o,
    output logic      trap_enter_o,
    output logic      trap_to_s_o,
    output logic      mret_o,
    output logic      sret_o,
    output exc_code_t trap_cause_o
);
    logic  is_mret, is_sret, ret_bad, ret_ok;
    xlen_t tvec, vec_pc;

    assign is_mret = ~trap_irq_i & (trap_code_i == EXC_MRET);
    assign is_sret = ~trap_irq_i & (trap_code_i == EXC_SRET);
    assign ret_bad = (2'(priv_o) < trap_code_i[1:0]) ||
                     (is_sret && priv_o == PRIV_S && mstatus_tsr_i);
    assign ret_ok  = (is_mret | is_sret) & ~ret_bad;

    // ecall cause depends on the mode it came from
    always_comb begin
        if (trap_irq_i) begin
            trap_cause_o = trap_code_i;
        end else if (trap_code_i == EXC_EC) begin
            trap_cause_o = {3'b010, 2'(priv_o)};
        end else if (is_mret | is_sret) begin
            trap_cause_o = EXC_II;
        end else begin
            trap_cause_o = trap_code_i;
        end
    end

    assign trap_to_s_o = (priv_o != PRIV_M) &
        (trap_irq_i ? mideleg_i[trap_cause_o] : medeleg_i[trap_cause_o]);

    assign trap_enter_o = trap_i & ~ret_ok;
    assign mret_o       = trap_i & ret_ok & is_mret;
    assign sret_o       = trap_i & ret_ok & is_sret;

    assign tvec   = trap_to_s_o ? stvec_i : mtvec_i;
    assign vec_pc = (trap_irq_i && tvec[1:0] == 2'b01) ?
                    {tvec[31:2], 2'b00} + {25'b0, trap_cause_o, 2'b00} : {tvec[31:2], 2'b00};
    assign target_pc_o = (ret_ok & is_mret) ? mepc_i :
                         (ret_ok & is_sret) ? sepc_i : vec_pc;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            priv_o <= PRIV_M;
        end else if (trap_enter_o) begin
            priv_o <= trap_to_s_o ? PRIV_S : PRIV_M;
        end else if (mret_o) begin
            priv_o <= mstatus_mpp_i;
        end else if (sret_o) begin
            priv_o <= mstatus_spp_i;
        end
    end

endmodule

//--- hdl/irq_select.sv
`timescale 1ns/1ps

module irq_select import csr_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       msip_i,
    input  logic       mtip_i,
    input  logic       meip_i,
    input  xlen_t      mie_i,
    input  xlen_t      mip_i,
    input  xlen_t      mideleg_i,
    input  logic       mstatus_mie_i,
    input  logic       mstatus_sie_i,
    input  priv_t      priv_i,
    output logic [2:0] hw_pending_o,
    output logic       irq_o,
    output exc_code_t  irq_code_o,
    output logic       irq_deleg_o
);
    logic [2:0] sync_s1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sync_s1      <= '0;
            hw_pending_o <= '0;
        end else begin
            sync_s1      <= {meip_i, mtip_i, msip_i};
            hw_pending_o <= sync_s1;
        end
    end

    // higher cause number wins, which gives mei sei mti sti msi ssi
    always_comb begin
        logic enabled;
        irq_o       = 1'b0;
        irq_code_o  = '0;
        irq_deleg_o = 1'b0;
        for (int i = 1; i < 12; i += 2) begin
            if (mideleg_i[i]) begin
                enabled = (priv_i == PRIV_S && mstatus_sie_i) || priv_i == PRIV_U;
            end else begin
                enabled = (priv_i == PRIV_M && mstatus_mie_i) || priv_i != PRIV_M;
            end
            if (enabled && mie_i[i] && mip_i[i]) begin
                irq_o       = 1'b1;
                irq_code_o  = exc_code_t'(i);
                irq_deleg_o = mideleg_i[i];
            end
        end
    end

endmodule

//--- hdl/csr_unit.sv
`timescale 1ns/1ps

module csr_unit import csr_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       csr_en_i,
    input  csr_op_t    csr_op_i,
    input  csr_addr_t  csr_addr_i,
    input  xlen_t      csr_src_i,
    input  logic [4:0] csr_uimm_i,
    input  logic       flush_i,
    input  logic       trap_i,
    input  exc_code_t  trap_code_i,
    input  logic       trap_irq_i,
    input  xlen_t      trap_pc_i,
    input  xlen_t      trap_inst_i,
    input  xlen_t      trap_vaddr_i,
    input  logic       msip_i,
    input  logic       mtip_i,
    input  logic       meip_i,
    output xlen_t      csr_rdata_o,
    output logic       csr_illegal_o,
    output xlen_t      target_pc_o,
    output priv_t      priv_mode_o,
    output logic       irq_o,
    output exc_code_t  irq_code_o,
    output logic       irq_deleg_o
);
    csr_addr_t rd_addr, wr_addr, commit_addr;
    xlen_t     rd_data, wr_data, commit_data;
    logic      rd_hit, wr_en, commit_en;
    xlen_t     mtvec, stvec, mepc, sepc, medeleg, mideleg, mie, mip;
    logic      mstatus_mie, mstatus_sie, mstatus_tsr;
    priv_t     mstatus_mpp, mstatus_spp;
    logic      trap_enter, trap_to_s, mret, sret;
    exc_code_t trap_cause;
    logic [2:0] hw_pending;

    csr_access u_access (
        .csr_en_i, .csr_op_i, .csr_addr_i, .csr_src_i, .csr_uimm_i,
        .priv_i(priv_mode_o), .rd_data_i(rd_data), .rd_hit_i(rd_hit),
        .rd_addr_o(rd_addr), .csr_rdata_o, .csr_illegal_o,
        .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data)
    );

    csr_write_pipe u_write_pipe (
        .clk, .rst, .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data), .flush_i,
        .commit_en_o(commit_en), .commit_addr_o(commit_addr), .commit_data_o(commit_data)
    );

    csr_file u_file (
        .clk, .rst, .commit_en_i(commit_en), .commit_addr_i(commit_addr),
        .commit_data_i(commit_data), .rd_addr_i(rd_addr), .priv_i(priv_mode_o),
        .trap_enter_i(trap_enter), .trap_to_s_i(trap_to_s), .mret_i(mret), .sret_i(sret),
        .trap_cause_i(trap_cause), .trap_irq_i, .trap_pc_i, .trap_inst_i, .trap_vaddr_i,
        .hw_pending_i(hw_pending), .rd_data_o(rd_data), .rd_hit_o(rd_hit),
        .mtvec_o(mtvec), .stvec_o(stvec), .mepc_o(mepc), .sepc_o(sepc),
        .medeleg_o(medeleg), .mideleg_o(mideleg), .mie_o(mie), .mip_o(mip),
        .mstatus_mie_o(mstatus_mie), .mstatus_sie_o(mstatus_sie),
        .mstatus_mpp_o(mstatus_mpp), .mstatus_spp_o(mstatus_spp), .mstatus_tsr_o(mstatus_tsr)
    );

    trap_ctrl u_trap (
        .clk, .rst, .trap_i, .trap_code_i, .trap_irq_i,
        .mtvec_i(mtvec), .stvec_i(stvec), .mepc_i(mepc), .sepc_i(sepc),
        .medeleg_i(medeleg), .mideleg_i(mideleg), .mstatus_mpp_i(mstatus_mpp),
        .mstatus_spp_i(mstatus_spp), .mstatus_tsr_i(mstatus_tsr),
        .priv_o(priv_mode_o), .target_pc_o, .trap_enter_o(trap_enter),
        .trap_to_s_o(trap_to_s), .mret_o(mret), .sret_o(sret), .trap_cause_o(trap_cause)
    );

    irq_select u_irq (
        .clk, .rst, .msip_i, .mtip_i, .meip_i, .mie_i(mie), .mip_i(mip),
        .mideleg_i(mideleg), .mstatus_mie_i(mstatus_mie), .mstatus_sie_i(mstatus_sie),
        .priv_i(priv_mode_o), .hw_pending_o(hw_pending), .irq_o, .irq_code_o, .irq_deleg_o
    );

endmodule

//--- tb/csr_unit_props.sv
`timescale 1ns/1ps

module csr_unit_props import csr_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       csr_illegal_i,
    input logic       commit_en_i,
    input logic [1:0] priv_mode_i,
    input logic       irq_i
);
    logic [1:0] since_rst;
    logic [1:0] ill_hist;

    // counts the first cycles out of reset, then holds
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            since_rst <= '0;
        end else if (since_rst != 2'd2) begin
            since_rst <= since_rst + 2'd1;
        end
    end

    // illegal flags of the last two request cycles
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ill_hist <= '0;
        end else begin
            ill_hist <= {ill_hist[0], csr_illegal_i};
        end
    end

    a_no_illegal_write: assert property (
        @(posedge clk) disable iff (!rst) !(ill_hist[1] && commit_en_i)
    ) else $error("illegal request reached the commit port");

    a_priv_legal: assert property (
        @(posedge clk) disable iff (!rst) priv_mode_i inside {PRIV_U, PRIV_S, PRIV_M}
    ) else $error("privilege mode holds the reserved encoding");

    a_irq_quiet: assert property (
        @(posedge clk) disable iff (!rst) (since_rst < 2'd2) |-> !irq_i
    ) else $error("interrupt raised in the first cycles after reset");

endmodule

bind csr_unit csr_unit_props u_props (
    .clk,
    .rst,
    .csr_illegal_i(csr_illegal_o),
    .commit_en_i(commit_en),
    .priv_mode_i(priv_mode_o),
    .irq_i(irq_o)
);

//--- tb/tb_csr_unit.sv
`timescale 1ns/1ps

module tb_csr_unit import csr_pkg::*; ();

    localparam int IRQ_TIMEOUT = 20;

    typedef enum logic [1:0] {ROW_CSR, ROW_TRAP, ROW_PINS} row_kind_t;

    // exp_val is read data for csr rows, target pc for traps
    // code is the trap code, or the expected irq code for pin rows
    typedef struct packed {
        row_kind_t  kind;
        csr_op_t    op;
        csr_addr_t  addr;
        xlen_t      src;
        logic [4:0] uimm;
        logic       flush;
        exc_code_t  code;
        xlen_t      pc;
        xlen_t      inst;
        xlen_t      vaddr;
        logic [2:0] pins;
        logic       chk_rd;
        logic       exp_ill;
        xlen_t      exp_val;
        priv_t      exp_mode;
        logic       exp_deleg;
    } row_t;

    row_t rows[$];

    logic       clk = 1'b0;
    logic       rst;
    logic       csr_en_i;
    csr_op_t    csr_op_i;
    csr_addr_t  csr_addr_i;
    xlen_t      csr_src_i;
    logic [4:0] csr_uimm_i;
    logic       flush_i;
    logic       trap_i;
    exc_code_t  trap_code_i;
    logic       trap_irq_i;
    xlen_t      trap_pc_i;
    xlen_t      trap_inst_i;
    xlen_t      trap_vaddr_i;
    logic       msip_i;
    logic       mtip_i;
    logic       meip_i;
    xlen_t      csr_rdata_o;
    logic       csr_illegal_o;
    xlen_t      target_pc_o;
    priv_t      priv_mode_o;
    logic       irq_o;
    exc_code_t  irq_code_o;
    logic       irq_deleg_o;

    csr_unit DUT (.*);

    always #4 clk = ~clk;

    task automatic check(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_csr(input csr_op_t op, input csr_addr_t addr, input xlen_t src,
                           input logic [4:0] uimm, input logic flush, input xlen_t exp_rd);
        row_t r;
        r = '0;
        r.kind    = ROW_CSR;
        r.op      = op;
        r.addr    = addr;
        r.src     = src;
        r.uimm    = uimm;
        r.flush   = flush;
        r.chk_rd  = 1'b1;
        r.exp_val = exp_rd;
        rows.push_back(r);
    endtask

    // rs with a zero source is a plain read
    task automatic add_read(input csr_addr_t addr, input xlen_t exp_rd);
        add_csr(CSR_RS, addr, 32'h0, 5'h0, 1'b0, exp_rd);
    endtask

    task automatic add_illegal(input csr_addr_t addr);
        row_t r;
        r = '0;
        r.kind    = ROW_CSR;
        r.op      = CSR_RS;
        r.addr    = addr;
        r.exp_ill = 1'b1;
        rows.push_back(r);
    endtask

    task automatic add_trap(input exc_code_t code, input xlen_t pc, input xlen_t inst,
                            input xlen_t vaddr, input xlen_t exp_pc, input priv_t exp_mode);
        row_t r;
        r = '0;
        r.kind     = ROW_TRAP;
        r.code     = code;
        r.pc       = pc;
        r.inst     = inst;
        r.vaddr    = vaddr;
        r.exp_val  = exp_pc;
        r.exp_mode = exp_mode;
        rows.push_back(r);
    endtask

    task automatic add_pins(input logic [2:0] pins, input exc_code_t exp_code,
                            input logic exp_deleg);
        row_t r;
        r = '0;
        r.kind      = ROW_PINS;
        r.pins      = pins;
        r.code      = exp_code;
        r.exp_deleg = exp_deleg;
        rows.push_back(r);
    endtask

    task automatic build_table(input xlen_t scratch);
        add_read(ADDR_MISA, MISA_VALUE);
        add_read(ADDR_MSTATUS, 32'h0);
        // scratch register through every operation
        add_csr(CSR_RW, ADDR_MSCRATCH, scratch, 5'h0, 1'b0, 32'h0);
        add_read(ADDR_MSCRATCH, scratch);
        add_csr(CSR_RSI, ADDR_MSCRATCH, 32'h0, 5'h12, 1'b0, scratch);
        add_csr(CSR_RCI, ADDR_MSCRATCH, 32'h0, 5'h00, 1'b0, scratch | 32'h12);
        add_csr(CSR_RC, ADDR_MSCRATCH, 32'hFFFF_0000, 5'h0, 1'b0, scratch | 32'h12);
        add_csr(CSR_RWI, ADDR_MSCRATCH, 32'h0, 5'h1F, 1'b0, (scratch | 32'h12) & 32'h0000_FFFF);
        add_read(ADDR_MSCRATCH, 32'h1F);
        // bit 1 of mtvec is reserved
        add_csr(CSR_RW, ADDR_MTVEC, 32'h8000_0103, 5'h0, 1'b0, 32'h0);
        add_read(ADDR_MTVEC, 32'h8000_0101);
        // sstatus is a masked window on mstatus
        add_csr(CSR_RSI, ADDR_SSTATUS, 32'h0, 5'h02, 1'b0, 32'h0);
        add_csr(CSR_RS, ADDR_MSTATUS, 32'h8, 5'h0, 1'b0, 32'h2);
        add_csr(CSR_RW, ADDR_SSTATUS, 32'hFFFF_FFFF, 5'h0, 1'b0, 32'h2);
        add_read(ADDR_MSTATUS, 32'h000C_012A);
        add_csr(CSR_RC, ADDR_SSTATUS, 32'h000C_0120, 5'h0, 1'b0, 32'h000C_0122);
        add_read(ADDR_MSTATUS, 32'h0000_000A);
        // flushed write must not land
        add_csr(CSR_RW, ADDR_MSCRATCH, 32'h5A5A_5A5A, 5'h0, 1'b1, 32'h1F);
        add_read(ADDR_MSCRATCH, 32'h1F);
        add_illegal(12'h7C0);
        // illegal instruction taken in m mode
        add_trap(EXC_II, 32'h0000_1004, 32'hDEAD_BEEF, 32'h0000_1234, 32'h8000_0100, PRIV_M);
        add_read(ADDR_MEPC, 32'h0000_1004);
        add_read(ADDR_MCAUSE, 32'h2);
        add_read(ADDR_MTVAL, 32'hDEAD_BEEF);
        // mpp to s, then set up the s side before leaving m
        add_csr(CSR_RC, ADDR_MSTATUS, 32'h0000_1000, 5'h0, 1'b0, 32'h0000_1882);
        add_csr(CSR_RW, ADDR_STVEC, 32'h0000_4000, 5'h0, 1'b0, 32'h0);
        add_csr(CSR_RW, ADDR_MEDELEG, 32'h0000_0004, 5'h0, 1'b0, 32'h0);
        add_trap(EXC_MRET, 32'h0, 32'h0, 32'h0, 32'h0000_1004, PRIV_S);
        add_illegal(ADDR_MSTATUS);
        add_trap(EXC_II, 32'h0000_2008, 32'h0000_0073, 32'h0, 32'h0000_4000, PRIV_S);
        add_read(ADDR_SEPC, 32'h0000_2008);
        add_read(ADDR_SCAUSE, 32'h2);
        add_read(ADDR_STVAL, 32'h0000_0073);
        add_read(ADDR_SSTATUS, 32'h0000_0120);
        // clear spp so sret drops to u
        add_csr(CSR_RC, ADDR_SSTATUS, 32'h0000_0100, 5'h0, 1'b0, 32'h0000_0120);
        add_trap(EXC_SRET, 32'h0, 32'h0, 32'h0, 32'h0000_2008, PRIV_U);
        // sret from u turns into an illegal instruction, delegated to s
        add_trap(EXC_SRET, 32'h0000_3000, 32'h1020_0073, 32'h0, 32'h0000_4000, PRIV_S);
        add_read(ADDR_SCAUSE, 32'h2);
        add_read(ADDR_STVAL, 32'h1020_0073);
        add_read(ADDR_SEPC, 32'h0000_3000);
        // ecall from s gives cause 9, not delegated
        add_trap(EXC_EC, 32'h0000_5000, 32'h0, 32'h0, 32'h8000_0100, PRIV_M);
        add_read(ADDR_MCAUSE, 32'h9);
        add_read(ADDR_MTVAL, 32'h0);
        add_csr(CSR_RW, ADDR_MIE, 32'h0000_0808, 5'h0, 1'b0, 32'h0);
        add_csr(CSR_RW, ADDR_MSTATUS, 32'h0000_0088, 5'h0, 1'b0, 32'h0000_08A0);
        add_read(ADDR_MSTATUS, 32'h0000_0088);
        add_trap(EXC_MRET, 32'h0, 32'h0, 32'h0, 32'h0000_5000, PRIV_U);
        add_pins(3'b001, IRQ_MSI, 1'b0);
        add_pins(3'b101, IRQ_MEI, 1'b0);
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            flush_i = 1'b0;
        end
    endtask

    task automatic apply_csr(input row_t r);
        csr_en_i   = 1'b1;
        csr_op_i   = r.op;
        csr_addr_i = r.addr;
        csr_src_i  = r.src;
        csr_uimm_i = r.uimm;
        #5;
        check("csr_illegal_o", xlen_t'(csr_illegal_o), xlen_t'(r.exp_ill));
        if (r.chk_rd) begin
            check("csr_rdata_o", csr_rdata_o, r.exp_val);
        end
        @(posedge clk);
        #1;
        csr_en_i = 1'b0;
        // flush lands one cycle behind its request
        flush_i  = r.flush;
    endtask

    task automatic apply_trap(input row_t r);
        trap_i       = 1'b1;
        trap_code_i  = r.code;
        trap_pc_i    = r.pc;
        trap_inst_i  = r.inst;
        trap_vaddr_i = r.vaddr;
        #5;
        check("target_pc_o", target_pc_o, r.exp_val);
        @(posedge clk);
        #1;
        trap_i = 1'b0;
        check("priv_mode_o", xlen_t'(priv_mode_o), xlen_t'(r.exp_mode));
    endtask

    task automatic apply_pins(input row_t r);
        int waited;
        waited = 0;
        {meip_i, mtip_i, msip_i} = r.pins;
        while (!(irq_o === 1'b1 && irq_code_o === r.code)) begin
            if (waited == IRQ_TIMEOUT) begin
                $display("interrupt code %0d never showed up on irq_code_o", r.code);
                $display("Testbench failed");
                $fatal(1, "interrupt wait timed out");
            end else begin
                @(posedge clk);
                #1;
                waited++;
            end
        end
        // two synchronizer flops between a pin and irq_o
        check("irq_o latency", xlen_t'(waited), 32'd2);
        check("irq_deleg_o", xlen_t'(irq_deleg_o), xlen_t'(r.exp_deleg));
    endtask

    initial begin
        xlen_t scratch;
        rst          = 1'b0;
        csr_en_i     = 1'b0;
        csr_op_i     = CSR_RW;
        csr_addr_i   = '0;
        csr_src_i    = '0;
        csr_uimm_i   = '0;
        flush_i      = 1'b0;
        trap_i       = 1'b0;
        trap_code_i  = '0;
        trap_irq_i   = 1'b0;
        trap_pc_i    = '0;
        trap_inst_i  = '0;
        trap_vaddr_i = '0;
        msip_i       = 1'b0;
        mtip_i       = 1'b0;
        meip_i       = 1'b0;
        void'($urandom(32'hb676cb72));
        scratch = $urandom();
        build_table(scratch);
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
        check("priv_mode_o", xlen_t'(priv_mode_o), xlen_t'(PRIV_M));
        check("irq_o", xlen_t'(irq_o), 32'h0);
        foreach (rows[i]) begin
            case (rows[i].kind)
                ROW_CSR:  apply_csr(rows[i]);
                ROW_TRAP: apply_trap(rows[i]);
                default:  apply_pins(rows[i]);
            endcase
            idle_cycles(3);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- vlog.f
hdl/csr_pkg.sv
hdl/csr_access.sv
hdl/csr_write_pipe.sv
hdl/csr_file.sv
hdl/trap_ctrl.sv
hdl/irq_select.sv
hdl/csr_unit.sv
tb/csr_unit_props.sv
tb/tb_csr_unit.sv

//--- Makefile
SIM = obj_dir/Vtb_csr_unit

.PHONY: all run clean

all: run

$(SIM): vlog.f $(wildcard hdl/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing --assert -j 0 --top-module tb_csr_unit -f vlog.f -o Vtb_csr_unit

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
